/* common/sha3pad_pkg.sv */
/*
 * SHA-3 padding stage shared definitions.
 * Holds modes, strengths, the Keccak rate table, the bytepad length
 * encoding and the function suffixes used across the padding blocks.
 */

package sha3pad_pkg;

  // beat width and N/S string width used when the top is not overridden
  parameter int MsgWidthDefault = 64;
  parameter int NsBytesDefault  = 38;

  // lane counter width, enough for the largest rate of 21 lanes
  parameter int KeccakCountW = 5;

  // hash function, the fourth code has no name and means pad10*1 only
  typedef enum logic [1:0] {
    Sha3   = 2'b00,
    Shake  = 2'b01,
    CShake = 2'b10
  } sha3_mode_e;

  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } keccak_strength_e;

  // block rate in 64-bit lanes, 168/144/136/104/72 bytes
  parameter logic [KeccakCountW-1:0] KeccakRate [5] = '{
    5'd21, 5'd18, 5'd17, 5'd13, 5'd9
  };

  // lane count of a strength, an unknown code gives zero
  function automatic logic [KeccakCountW-1:0] rate_lanes(keccak_strength_e s);
    logic [KeccakCountW-1:0] lanes;
    unique case (s)
      L128:    lanes = KeccakRate[0];
      L224:    lanes = KeccakRate[1];
      L256:    lanes = KeccakRate[2];
      L384:    lanes = KeccakRate[3];
      L512:    lanes = KeccakRate[4];
      default: lanes = '0;
    endcase
    return lanes;
  endfunction

  // left_encode of the rate in bytes
  // the length byte sits in the low half so it leads the byte stream
  function automatic logic [15:0] encode_bytepad_len(keccak_strength_e s);
    logic [7:0] rate_bytes;
    rate_bytes = {rate_lanes(s), 3'b000};
    return {rate_bytes, 8'h01};
  endfunction

  // domain suffix with the first pad10*1 one bit already appended
  function automatic logic [4:0] func_suffix(sha3_mode_e m);
    logic [4:0] suffix;
    unique case (m)
      Sha3:    suffix = 5'b00110;
      Shake:   suffix = 5'b11111;
      CShake:  suffix = 5'b00100;
      default: suffix = 5'b00001;
    endcase
    return suffix;
  endfunction

endpackage

/* common/pad_tail_if.sv */
/*
 * Tail path between the padding FSM and the tail beat generator.
 * The FSM steers buffer capture and clear, the generator returns
 * the suffix beat and the zero beat for the current lane.
 */

`timescale 1ns/1ps

interface pad_tail_if #(
  parameter int MsgWidth = 64
);

  // control from the padding FSM
  logic capture;
  logic clear;
  logic last_lane;

  // beats built from the buffered partial data
  logic [MsgWidth-1:0] suffix_beat;
  logic [MsgWidth-1:0] zero_beat;

  modport ctrl (
    output capture, clear, last_lane,
    input  suffix_beat, zero_beat
  );

  modport gen (
    input  capture, clear, last_lane,
    output suffix_beat, zero_beat
  );

endinterface

/* src/prefix_gen.sv */
/*
 * cSHAKE bytepad prefix source.
 * Places the N/S string above the encoded rate and returns one lane.
 */

`timescale 1ns/1ps

module prefix_gen #(
  parameter int MsgWidth = 64,
  parameter int NsBytes  = 38
) (
  input  sha3pad_pkg::keccak_strength_e         strength_i,
  input  logic [NsBytes*8-1:0]                  ns_data_i,
  input  logic [sha3pad_pkg::KeccakCountW-1:0]  idx_i,
  output logic [MsgWidth-1:0]                   lane_o
);

  // two bytes of left_encode(rate) in front of the string
  localparam int PrefixBytes = NsBytes + 2;
  localparam int LaneBytes   = MsgWidth / 8;
  localparam int PrefixLanes = (PrefixBytes + LaneBytes - 1) / LaneBytes;
  localparam int PrefixW     = PrefixLanes * MsgWidth;

  logic [PrefixW-1:0] prefix;

  // the unused top of the last lane reads as zero
  assign prefix = PrefixW'({ns_data_i, sha3pad_pkg::encode_bytepad_len(strength_i)});

  // lanes past the prefix zero-fill the rest of the block
  assign lane_o = (idx_i < PrefixLanes) ? prefix[idx_i*MsgWidth +: MsgWidth] : '0;

  // the whole prefix must fit below the smallest rate
  initial begin : prefix_fits_a
    assert (PrefixLanes < int'(sha3pad_pkg::KeccakRate[sha3pad_pkg::L512]))
      else $fatal(1, "prefix of %0d lanes does not fit the smallest rate", PrefixLanes);
  end

endmodule

/* src/tail_gen.sv */
/*
 * Tail beat generator for pad10*1.
 * Keeps a partial last beat and merges it with the function suffix,
 * and supplies the zero-fill beat with the end bit.
 */

`timescale 1ns/1ps

module tail_gen #(
  parameter int MsgWidth = 64
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [MsgWidth-1:0]      msg_data_i,
  input  logic [MsgWidth/8-1:0]    msg_strb_i,
  input  sha3pad_pkg::sha3_mode_e  mode_i,
  pad_tail_if.gen                  tail
);

  localparam int StrbW = MsgWidth / 8;

  // a partial beat never has its top byte, so seven bytes are enough
  logic [MsgWidth-9:0] buf_q;
  logic [StrbW-2:0]    strb_q;
  logic [2:0]          fill_cnt;
  logic [4:0]          suffix;

  always_ff @(posedge clk_i) begin
    if (tail.capture) begin
      buf_q <= msg_data_i[MsgWidth-9:0];
    end
  end

  // an empty strobe marks the buffer empty, so the data itself is never cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      strb_q <= '0;
    end else if (tail.capture) begin
      strb_q <= msg_strb_i[StrbW-2:0];
    end else if (tail.clear) begin
      strb_q <= '0;
    end
  end

  assign suffix   = sha3pad_pkg::func_suffix(mode_i);
  assign fill_cnt = 3'($countones(strb_q));

  // buffered bytes first, suffix in the byte right after them
  always_comb begin
    tail.suffix_beat = '0;
    for (int i = 0; i < StrbW - 1; i++) begin
      if (strb_q[i]) begin
        tail.suffix_beat[i*8 +: 8] = buf_q[i*8 +: 8];
      end
    end
    tail.suffix_beat[fill_cnt*8 +: 8] = {3'b000, suffix};
    // end bit of pad10*1 when this lane closes the block
    tail.suffix_beat[MsgWidth-1] = tail.last_lane;
  end

  assign tail.zero_beat = {tail.last_lane, {(MsgWidth-1){1'b0}}};

  // a captured strobe must be a run of low bytes without the top byte
  strb_contig_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tail.capture |-> !msg_strb_i[StrbW-1]
                     && ((msg_strb_i & StrbW'(msg_strb_i + 1'b1)) == '0));

  // the byte merge above is laid out for 64-bit beats
  initial begin : msg_width_a
    assert (MsgWidth == 64)
      else $fatal(1, "tail_gen supports 64-bit beats only");
  end

endmodule

/* pad_ctrl/pad_ctrl.sv */
/*
 * Padding FSM of the SHA-3 engine.
 * Counts lanes against the block rate, streams prefix, message and tail
 * beats to the Keccak engine and starts a permutation per full block.
 */

`timescale 1ns/1ps

module pad_ctrl #(
  parameter int MsgWidth = 64
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  input  logic                                  msg_valid_i,
  input  logic [MsgWidth-1:0]                   msg_data_i,
  input  logic [MsgWidth/8-1:0]                 msg_strb_i,
  output logic                                  msg_ready_o,

  output logic                                  keccak_valid_o,
  output logic [sha3pad_pkg::KeccakCountW-1:0]  keccak_addr_o,
  output logic [MsgWidth-1:0]                   keccak_data_o,
  input  logic                                  keccak_ready_i,
  output logic                                  keccak_run_o,
  input  logic                                  keccak_complete_i,

  input  sha3pad_pkg::sha3_mode_e               mode_i,
  input  sha3pad_pkg::keccak_strength_e         strength_i,

  input  logic                                  start_i,
  input  logic                                  process_i,
  input  logic                                  done_i,
  output logic                                  absorbed_o,

  // prefix lane lookup
  output logic [sha3pad_pkg::KeccakCountW-1:0]  prefix_idx_o,
  input  logic [MsgWidth-1:0]                   prefix_lane_i,

  pad_tail_if.ctrl                              tail
);

  localparam int CountW = sha3pad_pkg::KeccakCountW;

  typedef enum logic [3:0] {
    StIdle,
    StPrefix,
    StPrefixWait,
    StMessage,
    StMessageWait,
    StPad,
    StPadRun,
    StPad01,
    StFlush
  } pad_st_e;

  typedef enum logic [2:0] {
    SelNone,
    SelFifo,
    SelPrefix,
    SelSuffix,
    SelZero
  } beat_sel_e;

  pad_st_e   st_q, st_d;
  beat_sel_e sel;

  logic [CountW-1:0] rate;
  logic [CountW-1:0] lane_cnt_q;
  logic              clr_cnt;
  logic              block_full;
  logic              lane_ack;
  logic              msg_partial;
  logic              process_q;
  logic              absorbed_d;

  ////////////////////
  // lane counting
  ////////////////////

  assign rate        = sha3pad_pkg::rate_lanes(strength_i);
  assign block_full  = (lane_cnt_q == rate);
  assign lane_ack    = keccak_valid_o & keccak_ready_i;
  assign msg_partial = ~(&msg_strb_i);

  // the count rises by one per lane taken by the engine and clears at each run
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_cnt_q <= '0;
    end else if (clr_cnt) begin
      lane_cnt_q <= '0;
    end else if (lane_ack) begin
      lane_cnt_q <= lane_cnt_q + 1'b1;
    end
  end

  // the lane count doubles as the Keccak address and the prefix index
  assign keccak_addr_o  = lane_cnt_q;
  assign prefix_idx_o   = keccak_addr_o;
  assign tail.last_lane = ((lane_cnt_q + 1'b1) == rate);

  // process may arrive while the prefix is still in flight, so keep it until done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end else if (done_i) begin
      process_q <= 1'b0;
    end
  end

  ////////////////////
  // state machine
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q       <= StIdle;
      absorbed_o <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  always_comb begin
    st_d           = st_q;
    sel            = SelNone;
    keccak_valid_o = 1'b0;
    msg_ready_o    = 1'b0;
    keccak_run_o   = 1'b0;
    clr_cnt        = 1'b0;
    tail.capture   = 1'b0;
    tail.clear     = 1'b0;
    absorbed_d     = 1'b0;

    unique case (st_q)
      StIdle: begin
        // only cSHAKE carries a bytepad prefix block
        if (start_i) begin
          st_d = (mode_i == sha3pad_pkg::CShake) ? StPrefix : StMessage;
        end
      end

      StPrefix: begin
        sel = SelPrefix;
        if (block_full) begin
          keccak_run_o = 1'b1;
          clr_cnt      = 1'b1;
          st_d         = StPrefixWait;
        end else begin
          keccak_valid_o = 1'b1;
        end
      end

      StPrefixWait: begin
        if (keccak_complete_i) begin
          st_d = StMessage;
        end
      end

      StMessage: begin
        sel = SelFifo;
        if (msg_valid_i && msg_partial) begin
          // a partial beat goes into the tail buffer and never to the engine
          msg_ready_o  = keccak_ready_i;
          tail.capture = keccak_ready_i;
        end else if (block_full) begin
          keccak_run_o = 1'b1;
          clr_cnt      = 1'b1;
          st_d         = StMessageWait;
        end else if (process_q || process_i) begin
          st_d = StPad;
        end else begin
          keccak_valid_o = msg_valid_i;
          msg_ready_o    = keccak_ready_i;
        end
      end

      StMessageWait: begin
        if (keccak_complete_i) begin
          st_d = StMessage;
        end
      end

      StPad: begin
        // the suffix lane also carries the end bit when it closes the block
        sel            = SelSuffix;
        keccak_valid_o = 1'b1;
        if (lane_ack) begin
          tail.clear = 1'b1;
          st_d       = tail.last_lane ? StPadRun : StPad01;
        end
      end

      StPadRun: begin
        keccak_run_o = 1'b1;
        clr_cnt      = 1'b1;
        st_d         = StFlush;
      end

      StPad01: begin
        // zero lanes run up to the end of the block where the last one has bit 63 set
        sel = SelZero;
        if (block_full) begin
          keccak_run_o = 1'b1;
          clr_cnt      = 1'b1;
          st_d         = StFlush;
        end else begin
          keccak_valid_o = 1'b1;
        end
      end

      StFlush: begin
        tail.clear = 1'b1;
        if (keccak_complete_i) begin
          absorbed_d = 1'b1;
          st_d       = StIdle;
        end
      end

      default: begin
        st_d = StIdle;
      end
    endcase
  end

  ////////////////////
  // output beat
  ////////////////////

  always_comb begin
    unique case (sel)
      SelFifo:   keccak_data_o = msg_data_i;
      SelPrefix: keccak_data_o = prefix_lane_i;
      SelSuffix: keccak_data_o = tail.suffix_beat;
      SelZero:   keccak_data_o = tail.zero_beat;
      default:   keccak_data_o = '0;
    endcase
  end

  ////////////////////
  // assertions
  ////////////////////

  run_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    keccak_run_o |=> !keccak_run_o);

  absorbed_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    absorbed_o |=> !absorbed_o);

  addr_in_rate_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    keccak_valid_o |-> (keccak_addr_o < rate));

  // the zero-fill state is only entered with room left in the block
  pad01_not_last_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (st_q == StPad && st_d == StPad01) |=> (lane_cnt_q < rate));

endmodule

/* src/sha3pad_top.sv */
/*
 * SHA-3 padding stage top level.
 * Connects the padding FSM with the prefix and tail generators.
 */

`timescale 1ns/1ps

module sha3pad_top #(
  parameter int MsgWidth = sha3pad_pkg::MsgWidthDefault,
  parameter int NsBytes  = sha3pad_pkg::NsBytesDefault
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // message FIFO side
  input  logic                                  msg_valid_i,
  input  logic [MsgWidth-1:0]                   msg_data_i,
  input  logic [MsgWidth/8-1:0]                 msg_strb_i,
  output logic                                  msg_ready_o,

  // encoded N/S string, only read in cSHAKE mode
  input  logic [NsBytes*8-1:0]                  ns_data_i,

  // Keccak round engine side
  output logic                                  keccak_valid_o,
  output logic [sha3pad_pkg::KeccakCountW-1:0]  keccak_addr_o,
  output logic [MsgWidth-1:0]                   keccak_data_o,
  input  logic                                  keccak_ready_i,
  output logic                                  keccak_run_o,
  input  logic                                  keccak_complete_i,

  // configuration, stable from start to absorbed
  input  sha3pad_pkg::sha3_mode_e               mode_i,
  input  sha3pad_pkg::keccak_strength_e         strength_i,

  // control pulses
  input  logic                                  start_i,
  input  logic                                  process_i,
  input  logic                                  done_i,
  output logic                                  absorbed_o
);

  logic [sha3pad_pkg::KeccakCountW-1:0] prefix_idx;
  logic [MsgWidth-1:0]                  prefix_lane;

  pad_tail_if #(.MsgWidth(MsgWidth)) tail_if ();

  pad_ctrl #(
    .MsgWidth (MsgWidth)
  ) pad_ctrl_i (
    .clk_i,
    .rst_ni,
    .msg_valid_i,
    .msg_data_i,
    .msg_strb_i,
    .msg_ready_o,
    .keccak_valid_o,
    .keccak_addr_o,
    .keccak_data_o,
    .keccak_ready_i,
    .keccak_run_o,
    .keccak_complete_i,
    .mode_i,
    .strength_i,
    .start_i,
    .process_i,
    .done_i,
    .absorbed_o,
    .prefix_idx_o  (prefix_idx),
    .prefix_lane_i (prefix_lane),
    .tail          (tail_if.ctrl)
  );

  prefix_gen #(
    .MsgWidth (MsgWidth),
    .NsBytes  (NsBytes)
  ) prefix_gen_i (
    .strength_i,
    .ns_data_i,
    .idx_i  (prefix_idx),
    .lane_o (prefix_lane)
  );

  tail_gen #(
    .MsgWidth (MsgWidth)
  ) tail_gen_i (
    .clk_i,
    .rst_ni,
    .msg_data_i,
    .msg_strb_i,
    .mode_i,
    .tail (tail_if.gen)
  );

endmodule

/* bench/tb_sha3pad.sv */
/*
 * Testbench for the SHA-3 padding stage.
 * Models the Keccak engine, builds the expected blocks from the padding
 * rules and runs directed hashes over several modes and strengths.
 */

`timescale 1ns/1ps

module tb_sha3pad;

  localparam int MsgWidth = 64;
  localparam int NsBytes  = 38;
  // the lanes moved by all tests together size the watchdog
  localparam int TestLanes = 34 + 9 + 21 + 34 + 102;
  localparam logic [31:0] Seed = 32'h7fa4_39e8;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          msg_valid_i;
  logic [MsgWidth-1:0]           msg_data_i;
  logic [MsgWidth/8-1:0]         msg_strb_i;
  logic                          msg_ready_o;
  logic [NsBytes*8-1:0]          ns_data_i;
  logic                          keccak_valid_o;
  logic [4:0]                    keccak_addr_o;
  logic [MsgWidth-1:0]           keccak_data_o;
  logic                          keccak_ready_i;
  logic                          keccak_run_o;
  logic                          keccak_complete_i;
  sha3pad_pkg::sha3_mode_e       mode_i;
  sha3pad_pkg::keccak_strength_e strength_i;
  logic                          start_i;
  logic                          process_i;
  logic                          done_i;
  logic                          absorbed_o;

  // message bytes of the current hash and the lanes the engine should see
  logic [7:0]  msg_q[$];
  logic [63:0] exp_q[$];
  logic [63:0] image [32];

  int cur_rate;
  int blk_lanes;
  int runs;
  int exp_runs;
  int absorbed_cnt;
  int acc_beats;
  int run_wait;
  int val_errs;
  int proto_errs;
  bit ready_rand;
  bit need_prefix_run;
  bit prev_complete;
  logic [31:0] data_state;
  logic [31:0] ready_state;

  sha3pad_top #(
    .MsgWidth (MsgWidth),
    .NsBytes  (NsBytes)
  ) sha3pad_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] rand_byte();
    data_state = lcg_next(data_state);
    return data_state[31:24];
  endfunction

  // block rate in lanes for each strength
  function automatic int lanes_of(input sha3pad_pkg::keccak_strength_e s);
    case (s)
      sha3pad_pkg::L128: return 21;
      sha3pad_pkg::L224: return 18;
      sha3pad_pkg::L256: return 17;
      sha3pad_pkg::L384: return 13;
      sha3pad_pkg::L512: return 9;
      default:           return 0;
    endcase
  endfunction

  // domain bits and the first pad one bit form one byte
  function automatic logic [7:0] suffix_byte(input sha3pad_pkg::sha3_mode_e m);
    case (m)
      sha3pad_pkg::Sha3:   return 8'h06;
      sha3pad_pkg::Shake:  return 8'h1f;
      sha3pad_pkg::CShake: return 8'h04;
      default:             return 8'h01;
    endcase
  endfunction

  // the absorbed byte stream is cut into lanes little-endian
  task automatic build_expected(input sha3pad_pkg::sha3_mode_e m, input int lanes);
    logic [7:0]  stream[$];
    logic [63:0] lane;
    int          rbytes;
    rbytes = lanes * 8;
    exp_q.delete();
    if (m == sha3pad_pkg::CShake) begin
      // the bytepad prefix holds left_encode of the rate and N/S and is zero-filled to a block
      stream.push_back(8'h01);
      stream.push_back(rbytes[7:0]);
      for (int i = 0; i < NsBytes; i++) begin
        stream.push_back(ns_data_i[i*8 +: 8]);
      end
      while (stream.size() % rbytes != 0) begin
        stream.push_back(8'h00);
      end
    end
    foreach (msg_q[i]) begin
      stream.push_back(msg_q[i]);
    end
    stream.push_back(suffix_byte(m));
    while (stream.size() % rbytes != 0) begin
      stream.push_back(8'h00);
    end
    // the end bit of pad10*1 is the top bit of the block
    stream[stream.size()-1] = stream[stream.size()-1] | 8'h80;
    for (int i = 0; i < stream.size(); i += 8) begin
      for (int b = 0; b < 8; b++) begin
        lane[b*8 +: 8] = stream[i+b];
      end
      exp_q.push_back(lane);
    end
    exp_runs = stream.size() / rbytes;
  endtask

  ////////////////////
  // Keccak engine model
  ////////////////////

  task automatic check_block();
    logic [63:0] exp;
    if (blk_lanes != cur_rate) begin
      $display("block %0d carried %0d lanes instead of %0d", runs, blk_lanes, cur_rate);
      proto_errs++;
    end
    for (int i = 0; i < cur_rate; i++) begin
      if (exp_q.size() == 0) begin
        $display("permutation run %0d came with no expected block left", runs);
        proto_errs++;
        break;
      end
      exp = exp_q.pop_front();
      if (image[i] !== exp) begin
        $display("Fail at %0t ns: keccak_data_o lane %0d block %0d expected %h got %h",
                 $time, i, runs, exp, image[i]);
        val_errs++;
      end
      image[i] = 'x;
    end
    need_prefix_run = 1'b0;
    blk_lanes       = 0;
    runs++;
    run_wait = 10;
  endtask

  // outputs are sampled on the rising edge before the DUT registers update
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (msg_ready_o && !keccak_ready_i) begin
        $display("Fail at %0t ns: msg_ready_o expected 0 got 1", $time);
        val_errs++;
      end
      if (msg_valid_i && msg_ready_o) begin
        if (need_prefix_run) begin
          $display("message beat taken at %0t ns before the prefix block ran", $time);
          proto_errs++;
        end
        acc_beats++;
      end
      if (keccak_valid_o && keccak_ready_i) begin
        if (keccak_addr_o !== 5'(blk_lanes)) begin
          $display("Fail at %0t ns: keccak_addr_o expected %0d got %0d",
                   $time, blk_lanes, keccak_addr_o);
          val_errs++;
        end
        image[keccak_addr_o] = keccak_data_o;
        blk_lanes++;
      end
      if (keccak_run_o) begin
        check_block();
      end
      if (absorbed_o) begin
        // absorbed belongs in the cycle right after the final completion
        if (!prev_complete || runs != exp_runs) begin
          $display("absorbed pulse at %0t ns did not follow the final permutation", $time);
          proto_errs++;
        end
        absorbed_cnt++;
      end
      prev_complete = keccak_complete_i;
    end
  end

  // completion comes ten cycles after each run and the ready pattern changes every cycle
  always @(negedge clk_i) begin
    keccak_complete_i = 1'b0;
    if (run_wait > 0) begin
      run_wait--;
      if (run_wait == 0) begin
        keccak_complete_i = 1'b1;
      end
    end
    ready_state    = lcg_next(ready_state);
    keccak_ready_i = ready_rand ? ready_state[29] : 1'b1;
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic fill_message(input int nbytes);
    msg_q.delete();
    repeat (nbytes) msg_q.push_back(rand_byte());
  endtask

  // bytes past the message end get junk that the strobe masks
  task automatic send_message();
    logic [63:0] data;
    logic [7:0]  strb;
    int          nbeats;
    nbeats = (msg_q.size() + 7) / 8;
    for (int i = 0; i < nbeats; i++) begin
      strb = '0;
      for (int b = 0; b < 8; b++) begin
        if (i * 8 + b < msg_q.size()) begin
          data[b*8 +: 8] = msg_q[i*8+b];
          strb[b]        = 1'b1;
        end else begin
          data[b*8 +: 8] = rand_byte();
        end
      end
      @(negedge clk_i);
      msg_valid_i = 1'b1;
      msg_data_i  = data;
      msg_strb_i  = strb;
      @(posedge clk_i);
      while (!msg_ready_o) @(posedge clk_i);
    end
    @(negedge clk_i);
    msg_valid_i = 1'b0;
  endtask

  task automatic run_hash(input sha3pad_pkg::sha3_mode_e m,
                          input sha3pad_pkg::keccak_strength_e s, input bit rnd);
    int limit;
    int n;
    cur_rate = lanes_of(s);
    build_expected(m, cur_rate);
    runs            = 0;
    absorbed_cnt    = 0;
    acc_beats       = 0;
    blk_lanes       = 0;
    ready_rand      = rnd;
    need_prefix_run = (m == sha3pad_pkg::CShake);
    @(negedge clk_i);
    mode_i     = m;
    strength_i = s;
    start_i    = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    send_message();
    // message valid has just dropped on this edge
    process_i = 1'b1;
    @(negedge clk_i);
    process_i = 1'b0;
    limit = exp_runs * (cur_rate * 8 + 40) + 100;
    n     = 0;
    while (absorbed_cnt == 0 && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    repeat (5) @(negedge clk_i);
    if (absorbed_cnt != 1) begin
      $display("expected one absorbed pulse, saw %0d", absorbed_cnt);
      proto_errs++;
    end
    if (runs != exp_runs) begin
      $display("expected %0d permutation runs, saw %0d", exp_runs, runs);
      proto_errs++;
    end
    if (acc_beats != (msg_q.size() + 7) / 8) begin
      $display("%0d message beats were taken for %0d sent", acc_beats, (msg_q.size() + 7) / 8);
      proto_errs++;
    end
    done_i     = 1'b1;
    ready_rand = 1'b0;
    @(negedge clk_i);
    done_i = 1'b0;
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  // 240 bytes at 136 bytes per block, so the suffix lands in block two
  task automatic sha3_256_two_blocks();
    fill_message(240);
    run_hash(sha3pad_pkg::Sha3, sha3pad_pkg::L256, 1'b0);
  endtask

  task automatic sha3_512_partial_beat();
    fill_message(43);
    run_hash(sha3pad_pkg::Sha3, sha3pad_pkg::L512, 1'b0);
  endtask

  // 165 bytes leave a 5-byte beat in lane 20 which closes a SHAKE128 block
  task automatic shake128_tail_in_last_lane();
    fill_message(165);
    run_hash(sha3pad_pkg::Shake, sha3pad_pkg::L128, 1'b0);
  endtask

  task automatic cshake256_prefix();
    for (int i = 0; i < NsBytes; i++) begin
      ns_data_i[i*8 +: 8] = rand_byte();
    end
    fill_message(20);
    run_hash(sha3pad_pkg::CShake, sha3pad_pkg::L256, 1'b0);
  endtask

  // the same message runs twice with ready held high and then toggling
  task automatic shake256_backpressure();
    fill_message(300);
    run_hash(sha3pad_pkg::Shake, sha3pad_pkg::L256, 1'b0);
    run_hash(sha3pad_pkg::Shake, sha3pad_pkg::L256, 1'b1);
  endtask

  initial begin
    rst_ni            = 1'b0;
    msg_valid_i       = 1'b0;
    msg_data_i        = '0;
    msg_strb_i        = '0;
    ns_data_i         = '0;
    keccak_ready_i    = 1'b1;
    keccak_complete_i = 1'b0;
    mode_i            = sha3pad_pkg::Sha3;
    strength_i        = sha3pad_pkg::L256;
    start_i           = 1'b0;
    process_i         = 1'b0;
    done_i            = 1'b0;
    data_state        = Seed;
    ready_state       = Seed;
    run_wait          = 0;
    val_errs          = 0;
    proto_errs        = 0;
    ready_rand        = 1'b0;
    need_prefix_run   = 1'b0;
    prev_complete     = 1'b0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    sha3_256_two_blocks();
    sha3_512_partial_beat();
    shake128_tail_in_last_lane();
    cshake256_prefix();
    shake256_backpressure();
    $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
    if (val_errs + proto_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // about 200 cycles per lane of all tests
  initial begin
    repeat (TestLanes * 200) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the tests did not finish", TestLanes * 200);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* src.f */
common/sha3pad_pkg.sv
common/pad_tail_if.sv
src/prefix_gen.sv
src/tail_gen.sv
pad_ctrl/pad_ctrl.sv
src/sha3pad_top.sv
bench/tb_sha3pad.sv

/* Bender.yml */
package:
  name: sha3pad

sources:
  # shared package and interface first
  - common/sha3pad_pkg.sv
  - common/pad_tail_if.sv
  # design
  - src/prefix_gen.sv
  - src/tail_gen.sv
  - pad_ctrl/pad_ctrl.sv
  - src/sha3pad_top.sv
  # testbench
  - target: test
    files:
      - bench/tb_sha3pad.sv
